// File: tb.f
+incdir+tb
common/rename_pkg.sv
freelist/freelist_queue.sv
rtl/map_table.sv
rtl/rename_stage.sv
tb/rename_tb.sv

// File: Bender.yml
package:
  name: rename_stage

sources:
  # Design, in compile order
  - files:
      - common/rename_pkg.sv
      - freelist/freelist_queue.sv
      - rtl/map_table.sv
      - rtl/rename_stage.sv
  # Testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/rename_tb.sv

// File: tb/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Reference map table and free tag FIFO
rename_pkg::phys_tag_t model_map [rename_pkg::num_arch];
rename_pkg::phys_tag_t model_fifo [$];
// Uops due on uop_out, two per cycle, oldest first
rename_pkg::renamed_uop_t exp_q [$];
string test_name;

function automatic void model_reset();
    model_fifo.delete();
    exp_q.delete();
    // Identity mapping
    for (int i = 0; i < rename_pkg::num_arch; i++) begin
        model_map[i] = rename_pkg::phys_tag_t'(i);
    end
    // Unmapped tags, lowest at the head
    for (int i = rename_pkg::num_arch; i < rename_pkg::num_phys; i++) begin
        model_fifo.push_back(rename_pkg::phys_tag_t'(i));
    end
    // Output register is cleared by reset
    repeat (rename_pkg::rename_width) exp_q.push_back('0);
endfunction

// Stall when the FIFO cannot cover every destination of the group
function automatic bit model_stall(input req_group_t grp);
    int need;
    need = 0;
    for (int s = 0; s < rename_pkg::rename_width; s++) begin
        if (grp[s].valid && grp[s].rd != '0) begin
            need++;
        end
    end
    return model_fifo.size() < need;
endfunction

// Slots renamed one after the other
// Slot 1 then sees slot 0's new mapping, same as the in-group bypass
function automatic void model_rename(input req_group_t grp, input bit stalled);
    rename_pkg::renamed_uop_t u;
    for (int s = 0; s < rename_pkg::rename_width; s++) begin
        u = '0;
        if (!stalled && grp[s].valid) begin
            u.valid = 1'b1;
            u.ps1 = model_map[grp[s].rs1];
            u.ps2 = model_map[grp[s].rs2];
            // Register 0 never gets a tag
            if (grp[s].rd != '0) begin
                u.has_dest = 1'b1;
                u.pd = model_fifo.pop_front();
                u.old_pd = model_map[grp[s].rd];
                model_map[grp[s].rd] = u.pd;
            end
        end
        exp_q.push_back(u);
    end
endfunction

// Commit frees land at the tail, port 0 first
function automatic void model_free(input free_group_t frees);
    for (int k = 0; k < rename_pkg::rename_width; k++) begin
        if (frees[k].valid) begin
            model_fifo.push_back(frees[k].tag);
        end
    end
endfunction

task automatic check_uop(
    input int                       slot,
    input rename_pkg::renamed_uop_t exp_uop,
    input rename_pkg::renamed_uop_t act_uop
);
    if (act_uop !== exp_uop) begin
        $display("mismatch %s uop slot %0d: expected %p actual %p",
                 test_name, slot, exp_uop, act_uop);
        $display("Finished with errors");
        $fatal(1, "uop compare failed");
    end
endtask

task automatic check_stall(input logic exp_stall, input logic act_stall);
    if (act_stall !== exp_stall) begin
        $display("mismatch %s stall: expected %b actual %b", test_name, exp_stall, act_stall);
        $display("Finished with errors");
        $fatal(1, "stall compare failed");
    end
endtask

`endif

// File: tb/rename_tb.sv
`timescale 1ns/1ps

// Testbench for the two-wide rename stage
module rename_tb;

    typedef rename_pkg::rename_req_t [rename_pkg::rename_width-1:0] req_group_t;
    typedef rename_pkg::commit_free_t [rename_pkg::rename_width-1:0] free_group_t;

    logic clk = 1'b0;
    logic reset_n;
    req_group_t req;
    logic stall;
    rename_pkg::renamed_uop_t [rename_pkg::rename_width-1:0] uop_out;
    free_group_t free_in;

    // Old mappings seen on uop_out are freed oldest first
    rename_pkg::phys_tag_t pending [$];
    // Predicted stall of the group driven last
    bit last_stall;
    int unsigned lcg_state = 31;

    `include "rename_model.svh"

    always #4 clk = ~clk;

    rename_stage rename_stage_i (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (req),
        .stall   (stall),
        .uop_out (uop_out),
        .free_in (free_in)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic rename_pkg::rename_req_t make_slot(input int rs1, input int rs2, input int rd);
        rename_pkg::rename_req_t r;
        r.valid = 1'b1;
        r.rs1 = rename_pkg::arch_reg_t'(rs1);
        r.rs2 = rename_pkg::arch_reg_t'(rs2);
        r.rd = rename_pkg::arch_reg_t'(rd);
        return r;
    endfunction

    function automatic req_group_t rand_group();
        req_group_t g;
        for (int s = 0; s < rename_pkg::rename_width; s++) begin
            g[s].valid = (lcg_next() % 16) != 0;
            g[s].rs1 = rename_pkg::arch_reg_t'(lcg_next() % rename_pkg::num_arch);
            g[s].rs2 = rename_pkg::arch_reg_t'(lcg_next() % rename_pkg::num_arch);
            // No destination about one time in eight
            if (lcg_next() % 8 == 0) begin
                g[s].rd = '0;
            end else begin
                g[s].rd = rename_pkg::arch_reg_t'(1 + lcg_next() % (rename_pkg::num_arch - 1));
            end
        end
        // Bias toward in-group dependencies
        if (lcg_next() % 4 == 0) begin
            g[1].rs1 = g[0].rd;
        end
        if (lcg_next() % 8 == 0) begin
            g[1].rd = g[0].rd;
        end
        return g;
    endfunction

    // Drives one group and its frees, checks the outputs and advances the model
    task automatic run_cycle(input req_group_t grp, input bit allow_free);
        free_group_t frees;
        rename_pkg::renamed_uop_t exp_uop;
        bit exp_stall;
        frees = '0;
        @(posedge clk);
        if (allow_free) begin
            for (int k = 0; k < rename_pkg::rename_width; k++) begin
                if (lcg_next() % 4 != 0 && pending.size() > 0) begin
                    frees[k].valid = 1'b1;
                    frees[k].tag = pending.pop_front();
                end
            end
        end
        req <= grp;
        free_in <= frees;
        @(negedge clk);
        exp_stall = model_stall(grp);
        check_stall(exp_stall, stall);
        for (int s = 0; s < rename_pkg::rename_width; s++) begin
            exp_uop = exp_q.pop_front();
            check_uop(s, exp_uop, uop_out[s]);
            if (exp_uop.has_dest) begin
                pending.push_back(exp_uop.old_pd);
            end
        end
        // Pops use the FIFO from before the edge and frees go in behind
        model_rename(grp, exp_stall);
        model_free(frees);
        last_stall = exp_stall;
    endtask

    initial begin
        req_group_t grp;
        int waited;
        reset_n = 1'b0;
        req = '0;
        free_in = '0;
        last_stall = 1'b0;
        model_reset();
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        // Bypass, shared rd and register 0 sources
        test_name = "directed";
        grp[0] = make_slot(1, 2, 3);
        grp[1] = make_slot(3, 0, 3);
        run_cycle(grp, 1'b0);
        // No destination in slot 0
        grp[0] = make_slot(0, 5, 0);
        grp[1] = make_slot(4, 3, 4);
        run_cycle(grp, 1'b0);
        grp[0] = make_slot(3, 4, 5);
        grp[1] = make_slot(5, 5, 6);
        run_cycle(grp, 1'b0);
        // Invalid slot 0 takes no tag
        grp[0] = make_slot(7, 7, 7);
        grp[0].valid = 1'b0;
        grp[1] = make_slot(7, 8, 9);
        run_cycle(grp, 1'b0);

        // Commits withheld until the FIFO runs dry
        test_name = "exhaust";
        waited = 0;
        while (!last_stall) begin
            if (waited == 40) begin
                $display("stall never rose while commits were withheld");
                $display("Finished with errors");
                $fatal(1, "no stall");
            end
            grp = rand_group();
            run_cycle(grp, 1'b0);
            waited++;
        end

        // Held group goes through once frees arrive
        test_name = "refill";
        waited = 0;
        while (last_stall) begin
            if (waited == 40) begin
                $display("stall never cleared after tags were freed");
                $display("Finished with errors");
                $fatal(1, "stuck stall");
            end
            run_cycle(grp, 1'b1);
            waited++;
        end

        test_name = "random";
        for (int n = 0; n < 2000; n++) begin
            if (!last_stall) begin
                grp = rand_group();
            end
            run_cycle(grp, 1'b1);
        end

        // Last group out of the output register
        test_name = "drain";
        run_cycle('0, 1'b0);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: rtl/rename_stage.sv
`timescale 1ns/1ps

// Two-wide rename stage
// Looks up sources, takes fresh tags from the free list, registers the result
module rename_stage (
    input  logic                                                    clk,
    input  logic                                                    reset_n,
    input  rename_pkg::rename_req_t [rename_pkg::rename_width-1:0]  req,
    output logic                                                    stall,
    output rename_pkg::renamed_uop_t [rename_pkg::rename_width-1:0] uop_out,
    input  rename_pkg::commit_free_t [rename_pkg::rename_width-1:0] free_in
);

    // Slot needs a fresh tag
    logic [rename_pkg::rename_width-1:0] has_dest;
    // Number of tags the group needs
    logic [1:0] need;
    // Group accepted this cycle
    logic fire;
    logic [1:0] pop_count;

    rename_pkg::phys_tag_t [rename_pkg::rename_width-1:0] head_tags;
    rename_pkg::free_cnt_t free_count;

    // Map table ports
    rename_pkg::arch_reg_t [rename_pkg::num_src-1:0]      src_reg;
    rename_pkg::phys_tag_t [rename_pkg::num_src-1:0]      src_tag;
    rename_pkg::arch_reg_t [rename_pkg::rename_width-1:0] dst_reg;
    rename_pkg::phys_tag_t [rename_pkg::rename_width-1:0] old_tag;
    logic [rename_pkg::rename_width-1:0]                  wr_en;
    rename_pkg::arch_reg_t [rename_pkg::rename_width-1:0] wr_reg;

    // New destination tag per slot
    rename_pkg::phys_tag_t [rename_pkg::rename_width-1:0] pd;

    rename_pkg::renamed_uop_t [rename_pkg::rename_width-1:0] uop_d;
    rename_pkg::renamed_uop_t [rename_pkg::rename_width-1:0] uop_q;

    always_comb begin
        for (int s = 0; s < rename_pkg::rename_width; s++) begin
            has_dest[s] = req[s].valid && (req[s].rd != '0);
        end
    end

    assign need = {1'b0, has_dest[0]} + {1'b0, has_dest[1]};

    // A partial group is never renamed
    assign stall = free_count < rename_pkg::free_cnt_t'(need);
    assign fire = !stall;
    assign pop_count = fire ? need : 2'd0;

    // First destination in slot order takes the oldest tag
    assign pd[0] = head_tags[0];
    assign pd[1] = has_dest[0] ? head_tags[1] : head_tags[0];

    // Slot s sources go on table ports 2s and 2s+1
    always_comb begin
        for (int s = 0; s < rename_pkg::rename_width; s++) begin
            src_reg[2*s]   = req[s].rs1;
            src_reg[2*s+1] = req[s].rs2;
            dst_reg[s]     = req[s].rd;
            wr_en[s]       = fire && has_dest[s];
            wr_reg[s]      = req[s].rd;
        end
    end

    always_comb begin
        uop_d = '0;
        for (int s = 0; s < rename_pkg::rename_width; s++) begin
            if (fire && req[s].valid) begin
                uop_d[s].valid    = 1'b1;
                uop_d[s].has_dest = has_dest[s];
                // Register 0 maps to tag 0 and is never bypassed
                uop_d[s].ps1      = src_tag[2*s];
                uop_d[s].ps2      = src_tag[2*s+1];
                if (has_dest[s]) begin
                    uop_d[s].pd     = pd[s];
                    uop_d[s].old_pd = old_tag[s];
                end
            end
        end
        // Slot 1 sees slot 0's write before the table does
        if (uop_d[1].valid && has_dest[0]) begin
            if (req[1].rs1 == req[0].rd) begin
                uop_d[1].ps1 = pd[0];
            end
            if (req[1].rs2 == req[0].rd) begin
                uop_d[1].ps2 = pd[0];
            end
            // Same rd, so slot 0's new tag is what slot 1 replaces
            if (has_dest[1] && req[1].rd == req[0].rd) begin
                uop_d[1].old_pd = pd[0];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            uop_q <= '0;
        end else begin
            uop_q <= uop_d;
        end
    end

    assign uop_out = uop_q;

    freelist_queue freelist_queue_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .pop_count  (pop_count),
        .head_tags  (head_tags),
        .push       (free_in),
        .free_count (free_count)
    );

    map_table map_table_i (
        .clk     (clk),
        .reset_n (reset_n),
        .src_reg (src_reg),
        .src_tag (src_tag),
        .dst_reg (dst_reg),
        .old_tag (old_tag),
        .wr_en   (wr_en),
        .wr_reg  (wr_reg),
        .wr_tag  (pd)
    );

    // Fresh tag must differ from the one it replaces
    // Breaks if free list and map table ever share a tag
    fresh_tag: assert property (
        @(posedge clk) disable iff (!reset_n)
        (uop_out[0].has_dest -> uop_out[0].pd != uop_out[0].old_pd)
        && (uop_out[1].has_dest -> uop_out[1].pd != uop_out[1].old_pd)
    ) else $error("rename handed out a tag that is still mapped");

endmodule

// File: rtl/map_table.sv
`timescale 1ns/1ps

// Register alias table
// Combinational reads see the mapping from before the edge
module map_table (
    input  logic                                                  clk,
    input  logic                                                  reset_n,
    input  rename_pkg::arch_reg_t [rename_pkg::num_src-1:0]       src_reg,
    output rename_pkg::phys_tag_t [rename_pkg::num_src-1:0]       src_tag,
    input  rename_pkg::arch_reg_t [rename_pkg::rename_width-1:0]  dst_reg,
    output rename_pkg::phys_tag_t [rename_pkg::rename_width-1:0]  old_tag,
    input  logic [rename_pkg::rename_width-1:0]                   wr_en,
    input  rename_pkg::arch_reg_t [rename_pkg::rename_width-1:0]  wr_reg,
    input  rename_pkg::phys_tag_t [rename_pkg::rename_width-1:0]  wr_tag
);

    // Current tag of each architectural register
    rename_pkg::phys_tag_t map_q [rename_pkg::num_arch];

    // Source operand lookups
    always_comb begin
        for (int k = 0; k < rename_pkg::num_src; k++) begin
            src_tag[k] = map_q[src_reg[k]];
        end
    end

    // Previous mapping of each destination
    always_comb begin
        for (int k = 0; k < rename_pkg::rename_width; k++) begin
            old_tag[k] = map_q[dst_reg[k]];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // Register i holds tag i after reset
            for (int i = 0; i < rename_pkg::num_arch; i++) begin
                map_q[i] <= rename_pkg::phys_tag_t'(i);
            end
        end else begin
            // Later port overrides earlier one on the same register
            for (int p = 0; p < rename_pkg::rename_width; p++) begin
                // Entry 0 stays at tag 0
                if (wr_en[p] && wr_reg[p] != '0) begin
                    map_q[wr_reg[p]] <= wr_tag[p];
                end
            end
        end
    end

    // Stage must never request a mapping for register 0
    for (genvar p = 0; p < rename_pkg::rename_width; p++) begin : g_wr_chk
        no_zero_write: assert property (
            @(posedge clk) disable iff (!reset_n)
            wr_en[p] |-> (wr_reg[p] != '0)
        ) else $error("map write port %0d targets register 0", p);
    end

endmodule

// File: freelist/freelist_queue.sv
`timescale 1ns/1ps

// Circular queue of free physical tags
// Two dequeue ports at the head, two enqueue ports at the tail
module freelist_queue (
    input  logic                                                  clk,
    input  logic                                                  reset_n,
    input  logic [1:0]                                            pop_count,
    output rename_pkg::phys_tag_t [rename_pkg::rename_width-1:0]  head_tags,
    input  rename_pkg::commit_free_t [rename_pkg::rename_width-1:0] push,
    output rename_pkg::free_cnt_t                                 free_count
);

    // Tag storage
    rename_pkg::phys_tag_t entries [rename_pkg::free_depth];

    // Dequeue at head, enqueue at tail
    rename_pkg::free_ptr_t deq_ptr;
    rename_pkg::free_ptr_t enq_ptr;

    // Stored tag count
    rename_pkg::free_cnt_t count_q;

    // Number of valid push entries this cycle
    logic [1:0] push_n;

    // Second head slot
    rename_pkg::free_ptr_t deq_next;

    // Slot for push entry 1 right behind entry 0 when that one is valid
    rename_pkg::free_ptr_t enq_slot1;

    // Pointer advance with wrap at free_depth
    function automatic rename_pkg::free_ptr_t ptr_add(
        input rename_pkg::free_ptr_t ptr,
        input int unsigned           inc
    );
        int unsigned sum;
        sum = int'(ptr) + inc;
        if (sum >= rename_pkg::free_depth) begin
            sum = sum - rename_pkg::free_depth;
        end
        return rename_pkg::free_ptr_t'(sum);
    endfunction

    assign push_n = {1'b0, push[0].valid} + {1'b0, push[1].valid};

    assign deq_next = ptr_add(deq_ptr, 1);

    // Invalid entry 0 lets entry 1 take the tail slot
    assign enq_slot1 = push[0].valid ? ptr_add(enq_ptr, 1) : enq_ptr;

    // Two oldest tags as seen before the edge
    assign head_tags[0] = entries[deq_ptr];
    assign head_tags[1] = entries[deq_next];

    assign free_count = count_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // Tags num_arch and up are unmapped after reset, oldest at head
            for (int i = 0; i < rename_pkg::free_depth; i++) begin
                entries[i] <= rename_pkg::phys_tag_t'(rename_pkg::num_arch + i);
            end
            deq_ptr <= '0;
            // Queue starts full, so tail wraps onto head
            enq_ptr <= '0;
            count_q <= rename_pkg::free_cnt_t'(rename_pkg::free_depth);
        end else begin
            // Packed in port order
            if (push[0].valid) begin
                entries[enq_ptr] <= push[0].tag;
            end
            if (push[1].valid) begin
                entries[enq_slot1] <= push[1].tag;
            end
            enq_ptr <= ptr_add(enq_ptr, push_n);
            deq_ptr <= ptr_add(deq_ptr, pop_count);
            // Net change of pushes minus pops
            count_q <= count_q + rename_pkg::free_cnt_t'(push_n)
                       - rename_pkg::free_cnt_t'(pop_count);
        end
    end

    // Rename side must check occupancy before popping
    pop_within_count: assert property (
        @(posedge clk) disable iff (!reset_n)
        pop_count <= free_count
    ) else $error("freelist pop of %0d with only %0d tags", pop_count, free_count);

    // Commit never returns more tags than were handed out
    no_overflow: assert property (
        @(posedge clk) disable iff (!reset_n)
        (int'(count_q) + int'(push_n) - int'(pop_count)) <= rename_pkg::free_depth
    ) else $error("freelist overflow, count %0d push %0d", count_q, push_n);

endmodule

// File: common/rename_pkg.sv
// Shared sizes and slot types for the two-wide rename stage
package rename_pkg;

    // Register file sizes
    localparam int num_arch = 32;
    localparam int num_phys = 64;

    // Instructions renamed per group
    localparam int rename_width = 2;

    // Two source operands per instruction
    localparam int num_src = 2 * rename_width;

    // Tags not covered by the reset identity mapping
    localparam int free_depth = num_phys - num_arch;

    // Index and tag widths
    localparam int arch_w = $clog2(num_arch);
    localparam int phys_w = $clog2(num_phys);

    // Free list pointer and occupancy widths
    // Occupancy must also hold the full value free_depth
    localparam int free_ptr_w = $clog2(free_depth);
    localparam int free_cnt_w = $clog2(free_depth + 1);

    typedef logic [arch_w-1:0] arch_reg_t;
    typedef logic [phys_w-1:0] phys_tag_t;
    typedef logic [free_ptr_w-1:0] free_ptr_t;
    typedef logic [free_cnt_w-1:0] free_cnt_t;

    // One incoming instruction slot
    // rd of 0 means no destination
    typedef struct packed {
        logic      valid;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
    } rename_req_t;

    // One renamed slot as seen downstream
    typedef struct packed {
        logic      valid;
        logic      has_dest;
        phys_tag_t ps1;
        phys_tag_t ps2;
        phys_tag_t pd;
        phys_tag_t old_pd;
    } renamed_uop_t;

    // Tag released by commit
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } commit_free_t;

endpackage
